// File: build.f
rtl/exec_pkg.sv
rtl/alu_decode.sv
rtl/alu.sv
rtl/result_fifo.sv
rtl/exec_unit.sv
verif/exec_checker.sv
verif/exec_tb.sv

// File: Bender.yml
package:
  name: exec_unit

sources:
  - files:
      - rtl/exec_pkg.sv
      - rtl/alu_decode.sv
      - rtl/alu.sv
      - rtl/result_fifo.sv
      - rtl/exec_unit.sv
  - target: simulation
    files:
      - verif/exec_checker.sv
      - verif/exec_tb.sv

// File: verif/exec_tb.sv
`timescale 1ns/1ps

module exec_tb;
    localparam int FIFO_DEPTH  = 4;
    localparam int OUT_CREDITS = 2;
    localparam int N_OPS       = 60;
    localparam int N_BP        = 80;
    localparam int TOTAL_OPS   = 4 * N_OPS + N_BP + FIFO_DEPTH + OUT_CREDITS;

    logic             clk;
    logic             reset;
    logic             in_valid;
    exec_pkg::instr_t instr;
    logic [31:0]      rs_value;
    logic [31:0]      rt_value;
    logic             in_credit;
    logic             out_valid;
    logic [31:0]      out_result;
    logic [4:0]       out_dest;
    exec_pkg::flags_t out_flags;
    logic             out_credit;

    int err_count;
    int pending;
    int checked;
    int tb_errors;
    int avail;
    bit hold;
    bit stall_mode;

    exec_unit #(.FIFO_DEPTH(FIFO_DEPTH), .OUT_CREDITS(OUT_CREDITS)) dut (
        .clk(clk), .reset(reset), .in_valid(in_valid), .instr(instr),
        .rs_value(rs_value), .rt_value(rt_value), .in_credit(in_credit),
        .out_valid(out_valid), .out_result(out_result), .out_dest(out_dest),
        .out_flags(out_flags), .out_credit(out_credit)
    );

    exec_checker #(.OUT_CREDITS(OUT_CREDITS)) chk (
        .clk(clk), .reset(reset), .in_valid(in_valid), .instr(instr),
        .rs_value(rs_value), .rt_value(rt_value), .in_credit(in_credit),
        .out_valid(out_valid), .out_result(out_result), .out_dest(out_dest),
        .out_flags(out_flags), .out_credit(out_credit),
        .err_count(err_count), .pending(pending), .checked(checked)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ==============================
    // Stimulus helpers
    // ==============================
    task automatic tick();
        @(posedge clk);
        avail += int'(in_credit);    // Upstream credit returned
    endtask

    function automatic logic [31:0] pick_operand();
        case ($urandom % 5)
            0: return 32'h7fffffff;
            1: return 32'h80000000;
            2: return 32'hffffffff;
            default: return $urandom;
        endcase
    endfunction

    function automatic logic [31:0] make_word(input int cat);
        logic [5:0] f1[4]  = '{6'h20, 6'h21, 6'h22, 6'h23};
        logic [5:0] i1[2]  = '{6'h08, 6'h09};
        logic [5:0] f2[6]  = '{6'h24, 6'h25, 6'h26, 6'h27, 6'h2a, 6'h2b};
        logic [5:0] i2[6]  = '{6'h0c, 6'h0d, 6'h0e, 6'h0a, 6'h0b, 6'h0f};
        logic [5:0] f3[6]  = '{6'h00, 6'h02, 6'h03, 6'h04, 6'h06, 6'h07};
        logic [5:0] bad[9] = '{6'h01, 6'h05, 6'h08, 6'h0a, 6'h18, 6'h19, 6'h1a, 6'h2c, 6'h3f};
        logic [25:0] body;
        body = $urandom;
        case (cat)
            1: if ($urandom % 3 == 0) return {i1[$urandom % 2], body};
               else return {6'h00, body[25:6], f1[$urandom % 4]};
            2: if ($urandom % 2 == 0) return {i2[$urandom % 6], body};
               else return {6'h00, body[25:6], f2[$urandom % 6]};
            3: return {6'h00, body[25:6], f3[$urandom % 6]};
            4: if ($urandom % 2 == 0) return {6'h10 + 6'($urandom % 48), body};
               else return {6'h00, body[25:6], bad[$urandom % 9]};
            default: return make_word(1 + $urandom % 3);
        endcase
    endfunction

    task automatic send_ops(input int cat, input int n);
        int sent;
        sent = 0;
        while (sent < n) begin
            tick();
            if (avail > 0 && ($urandom % 4 != 0)) begin
                in_valid <= 1'b1;
                instr    <= make_word(cat);
                rs_value <= pick_operand();
                rt_value <= (cat == 3 && $urandom % 2) ? (32'h80000000 | $urandom) : pick_operand();
                avail--;
                sent++;
            end else begin
                in_valid <= 1'b0;
            end
        end
        tick();
        in_valid <= 1'b0;
    endtask

    task automatic drain(input string name, input int err_before);
        int cycles;
        cycles = 0;
        while (pending != 0 && cycles < 2000) begin
            tick();
            cycles++;
        end
        if (pending != 0) begin
            $display("%s: %0d results missing after drain", name, pending);
            tb_errors++;
        end
        $display("%s: done, %0d new errors", name, err_count + tb_errors - err_before);
    endtask

    // Consumer returns one credit per received result
    initial begin
        int owed;
        int wait_cyc;
        int pause_left;
        owed = 0;
        wait_cyc = 0;
        pause_left = 0;
        forever begin
            @(posedge clk);
            if (reset) begin
                owed = 0;
                out_credit <= 1'b0;
            end else begin
                if (out_valid) owed++;
                if (stall_mode && pause_left == 0 && $urandom % 30 == 0) begin
                    pause_left = 20 + $urandom % 30;
                end
                if (!hold && pause_left == 0 && owed > 0 && wait_cyc == 0) begin
                    out_credit <= 1'b1;
                    owed--;
                    wait_cyc = $urandom % 4;
                end else begin
                    out_credit <= 1'b0;
                    if (wait_cyc > 0) wait_cyc--;
                end
                if (pause_left > 0) pause_left--;
            end
        end
    end

    initial begin
        #(TOTAL_OPS * 40 * 30);
        $display("Watchdog expired before the tests finished");
        $display("SIMULATION FAILED");
        $finish;
    end

    // ==============================
    // Test sequence
    // ==============================
    initial begin
        int e0;
        int accepted;
        void'($urandom(32'ha0040d35));
        reset      = 1'b1;
        in_valid   = 1'b0;
        instr      = '0;
        rs_value   = '0;
        rt_value   = '0;
        out_credit = 1'b0;
        tb_errors  = 0;
        avail      = FIFO_DEPTH;
        hold       = 1'b1;
        stall_mode = 1'b0;
        repeat (10) @(posedge clk);
        reset <= 1'b0;

        // Reset state and queue depth
        e0 = err_count + tb_errors;
        repeat (5) begin
            tick();
            if (out_valid || in_credit) begin
                $display("out_valid or in_credit high before any instruction");
                tb_errors++;
            end
        end
        accepted = 0;
        repeat (40) begin
            tick();
            if (avail > 0) begin
                in_valid <= 1'b1;
                instr    <= make_word(5);
                rs_value <= pick_operand();
                rt_value <= pick_operand();
                avail--;
                accepted++;
            end else begin
                in_valid <= 1'b0;
            end
        end
        // Initial output credits free that many slots on top of the queue
        if (accepted != FIFO_DEPTH + OUT_CREDITS) begin
            $display("accepted %0d instructions with credit withheld, expected %0d",
                     accepted, FIFO_DEPTH + OUT_CREDITS);
            tb_errors++;
        end
        hold <= 1'b0;
        drain("test 6 reset state", e0);

        e0 = err_count + tb_errors;
        send_ops(1, N_OPS);
        drain("test 1 arithmetic", e0);
        e0 = err_count + tb_errors;
        send_ops(2, N_OPS);
        drain("test 2 logic compare lui", e0);
        e0 = err_count + tb_errors;
        send_ops(3, N_OPS);
        drain("test 3 shifts", e0);
        e0 = err_count + tb_errors;
        send_ops(4, N_OPS);
        drain("test 4 illegal", e0);
        e0 = err_count + tb_errors;
        stall_mode <= 1'b1;
        send_ops(5, N_BP);
        drain("test 5 back-pressure", e0);
        stall_mode <= 1'b0;

        $display("checked %0d results, %0d errors", checked, err_count + tb_errors);
        if (err_count + tb_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: verif/exec_checker.sv
`timescale 1ns/1ps

module exec_checker #(
    parameter int OUT_CREDITS = 2
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        in_valid,
    input  logic [31:0] instr,
    input  logic [31:0] rs_value,
    input  logic [31:0] rt_value,
    input  logic        in_credit,
    input  logic        out_valid,
    input  logic [31:0] out_result,
    input  logic [4:0]  out_dest,
    input  logic [5:0]  out_flags,
    input  logic        out_credit,
    output int          err_count,
    output int          pending,
    output int          checked
);
    logic [42:0] exp_q[$];    // flags, dest, result
    int          cred;

    // ==============================
    // Reference model
    // ==============================
    function automatic logic [42:0] expect_result(input logic [31:0] w,
                                                  input logic [31:0] rs,
                                                  input logic [31:0] rt);
        logic [5:0]  op;
        logic [5:0]  fn;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r;
        logic [32:0] wide;
        logic [4:0]  dest;
        logic        c;
        logic        v;
        logic        cmp;
        logic        ill;
        op   = w[31:26];
        fn   = w[5:0];
        a    = rs;
        b    = {{16{w[15]}}, w[15:0]};
        r    = 32'd0;
        dest = w[20:16];
        c    = 1'b0;
        v    = 1'b0;
        cmp  = 1'b0;
        ill  = 1'b0;
        if (op == 6'h00) begin
            b    = rt;
            dest = w[15:11];
            case (fn)
                6'h20, 6'h21, 6'h22, 6'h23: ;    // Shared add/sub handling below
                6'h24: r = a & b;
                6'h25: r = a | b;
                6'h26: r = a ^ b;
                6'h27: r = ~(a | b);
                6'h2a: cmp = $signed(a) < $signed(b);
                6'h2b: cmp = a < b;
                6'h00: r = b << w[10:6];
                6'h02: r = b >> w[10:6];
                6'h03: r = $signed(b) >>> w[10:6];
                6'h04: r = b << a[4:0];
                6'h06: r = b >> a[4:0];
                6'h07: r = $signed(b) >>> a[4:0];
                default: ill = 1'b1;    // JR lands here too
            endcase
        end else begin
            case (op)
                6'h08: fn = 6'h20;
                6'h09: fn = 6'h21;
                6'h0a: cmp = $signed(a) < $signed(b);
                6'h0b: cmp = a < b;
                6'h0c: r = a & {16'h0, w[15:0]};
                6'h0d: r = a | {16'h0, w[15:0]};
                6'h0e: r = a ^ {16'h0, w[15:0]};
                6'h0f: r = {w[15:0], 16'h0};
                default: ill = 1'b1;
            endcase
            if (op != 6'h08 && op != 6'h09) begin
                fn = 6'h3f;    // Keep the add/sub branch out
            end
        end
        if (!ill && (fn == 6'h20 || fn == 6'h21)) begin
            wide = {1'b0, a} + {1'b0, b};
            r    = wide[31:0];
            if (fn == 6'h20) v = (a[31] == b[31]) && (r[31] != a[31]);
            else c = wide[32];
        end
        if (!ill && op == 6'h00 && (fn == 6'h22 || fn == 6'h23)) begin
            r = a - b;
            if (fn == 6'h22) v = (a[31] != b[31]) && (r[31] != a[31]);
            else c = a < b;    // Borrow
        end
        if (cmp) r = 32'd1;
        if (ill) return {6'b100001, dest, 32'd0};
        return {ill, cmp, v, r[31], c, (r == 32'd0), dest, r};
    endfunction

    // ==============================
    // Compare
    // ==============================
    always @(posedge clk) begin
        logic [42:0] e;
        if (reset) begin
            exp_q.delete();
            cred    = OUT_CREDITS;
            pending = 0;
        end else begin
            if (out_valid) begin
                if (cred == 0) begin
                    $display("out_valid asserted with zero output credits at %0t", $time);
                    err_count++;
                end
                if (exp_q.size() == 0) begin
                    $display("out_valid with no instruction outstanding at %0t", $time);
                    err_count++;
                end else begin
                    e = exp_q.pop_front();
                    checked++;
                    if (out_result !== e[31:0]) begin
                        $display("ERR out_result exp %08h got %08h", e[31:0], out_result);
                        err_count++;
                    end
                    if (out_dest !== e[36:32]) begin
                        $display("ERR out_dest exp %02h got %02h", e[36:32], out_dest);
                        err_count++;
                    end
                    if (out_flags !== e[42:37]) begin
                        $display("ERR out_flags exp %02h got %02h", e[42:37], out_flags);
                        err_count++;
                    end
                end
            end
            if (in_credit !== out_valid) begin
                $display("in_credit does not match the output pop at %0t", $time);
                err_count++;
            end
            cred = cred + int'(out_credit) - int'(out_valid);
            if (in_valid) exp_q.push_back(expect_result(instr, rs_value, rt_value));
            pending = exp_q.size();
        end
    end

    initial begin
        err_count = 0;
        checked   = 0;
        pending   = 0;
        cred      = OUT_CREDITS;
    end

endmodule

// File: rtl/exec_unit.sv
`timescale 1ns/1ps

module exec_unit #(
    parameter int FIFO_DEPTH  = 4,
    parameter int OUT_CREDITS = 2
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             in_valid,
    input  exec_pkg::instr_t instr,
    input  logic [31:0]      rs_value,
    input  logic [31:0]      rt_value,
    output logic             in_credit,
    output logic             out_valid,
    output logic [31:0]      out_result,
    output logic [4:0]       out_dest,
    output exec_pkg::flags_t out_flags,
    input  logic             out_credit
);
    import exec_pkg::*;

    // ==============================
    // Decode to ALU
    // ==============================
    logic        dec_valid;
    aluc_t       dec_aluc;
    logic [31:0] dec_a;
    logic [31:0] dec_b;
    logic [4:0]  dec_dest;
    logic        dec_illegal;

    // ALU to queue
    logic        alu_valid;
    logic [31:0] alu_result;
    logic [4:0]  alu_dest;
    flags_t      alu_flags;

    alu_decode u_decode (
        .clk         (clk),
        .reset       (reset),
        .in_valid    (in_valid),
        .instr       (instr),
        .rs_value    (rs_value),
        .rt_value    (rt_value),
        .dec_valid   (dec_valid),
        .dec_aluc    (dec_aluc),
        .dec_a       (dec_a),
        .dec_b       (dec_b),
        .dec_dest    (dec_dest),
        .dec_illegal (dec_illegal)
    );

    alu u_alu (
        .clk         (clk),
        .reset       (reset),
        .dec_valid   (dec_valid),
        .dec_aluc    (dec_aluc),
        .dec_a       (dec_a),
        .dec_b       (dec_b),
        .dec_dest    (dec_dest),
        .dec_illegal (dec_illegal),
        .alu_valid   (alu_valid),
        .alu_result  (alu_result),
        .alu_dest    (alu_dest),
        .alu_flags   (alu_flags)
    );

    result_fifo #(
        .FIFO_DEPTH  (FIFO_DEPTH),
        .OUT_CREDITS (OUT_CREDITS)
    ) u_fifo (
        .clk        (clk),
        .reset      (reset),
        .alu_valid  (alu_valid),
        .alu_result (alu_result),
        .alu_dest   (alu_dest),
        .alu_flags  (alu_flags),
        .out_credit (out_credit),
        .out_valid  (out_valid),
        .out_result (out_result),
        .out_dest   (out_dest),
        .out_flags  (out_flags),
        .in_credit  (in_credit)
    );

endmodule

// File: rtl/result_fifo.sv
`timescale 1ns/1ps

module result_fifo #(
    parameter int FIFO_DEPTH  = 4,
    parameter int OUT_CREDITS = 2
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             alu_valid,
    input  logic [31:0]      alu_result,
    input  logic [4:0]       alu_dest,
    input  exec_pkg::flags_t alu_flags,
    input  logic             out_credit,
    output logic             out_valid,
    output logic [31:0]      out_result,
    output logic [4:0]       out_dest,
    output exec_pkg::flags_t out_flags,
    output logic             in_credit
);
    import exec_pkg::*;

    localparam int PTR_W  = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W  = $clog2(FIFO_DEPTH + 1);
    localparam int CRED_W = $clog2(OUT_CREDITS + 2);    // One spare bit to catch overflow

    logic [31:0] mem_result [FIFO_DEPTH];
    logic [4:0]  mem_dest   [FIFO_DEPTH];
    flags_t      mem_flags  [FIFO_DEPTH];

    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;
    logic [CRED_W-1:0] credits;
    logic              empty;
    logic              pop;

    assign empty = (count == '0);
    assign pop   = (!empty || alu_valid) && (credits != '0);    // Bypass when empty

    // ==============================
    // Pointers and counters
    // ==============================
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            credits   <= CRED_W'(OUT_CREDITS);
            out_valid <= 1'b0;
        end else begin
            if (alu_valid) begin
                wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count     <= count + CNT_W'(alu_valid) - CNT_W'(pop);
            credits   <= credits + CRED_W'(out_credit) - CRED_W'(pop);
            out_valid <= pop;
        end
    end

    always_ff @(posedge clk) begin
        if (alu_valid) begin
            mem_result[wr_ptr] <= alu_result;
            mem_dest[wr_ptr]   <= alu_dest;
            mem_flags[wr_ptr]  <= alu_flags;
        end
        if (pop) begin
            out_result <= empty ? alu_result : mem_result[rd_ptr];
            out_dest   <= empty ? alu_dest   : mem_dest[rd_ptr];
            out_flags  <= empty ? alu_flags  : mem_flags[rd_ptr];
        end
    end

    assign in_credit = out_valid;    // One slot freed per pop

    // Source spent more than FIFO_DEPTH credits
    a_no_overflow: assert property (@(posedge clk) disable iff (reset)
        alu_valid |-> (count < FIFO_DEPTH))
        else $error("result_fifo: write while full");

    a_credit_bound: assert property (@(posedge clk) disable iff (reset)
        credits <= OUT_CREDITS)
        else $error("result_fifo: consumer returned more credits than granted");

endmodule

// File: rtl/alu.sv
`timescale 1ns/1ps

module alu (
    input  logic             clk,
    input  logic             reset,
    input  logic             dec_valid,
    input  exec_pkg::aluc_t  dec_aluc,
    input  logic [31:0]      dec_a,
    input  logic [31:0]      dec_b,
    input  logic [4:0]       dec_dest,
    input  logic             dec_illegal,
    output logic             alu_valid,
    output logic [31:0]      alu_result,
    output logic [4:0]       alu_dest,
    output exec_pkg::flags_t alu_flags
);
    import exec_pkg::*;

    logic [32:0] res;          // Bit 32 holds carry or borrow
    logic        carry;
    logic        ovf;
    logic        cmp;
    logic [31:0] nxt_result;
    flags_t      nxt_flags;

    // ==============================
    // Operation
    // ==============================
    always_comb begin
        res   = 33'd0;
        carry = 1'b0;
        ovf   = 1'b0;
        cmp   = 1'b0;
        case (dec_aluc)
            ALUC_ADD: begin
                res = {1'b0, dec_a} + {1'b0, dec_b};
                ovf = (dec_a[31] == dec_b[31]) && (res[31] != dec_a[31]);
            end
            ALUC_ADDU: begin
                res   = {1'b0, dec_a} + {1'b0, dec_b};
                carry = res[32];
            end
            ALUC_SUB: begin
                res = {1'b0, dec_a} - {1'b0, dec_b};
                ovf = (dec_a[31] != dec_b[31]) && (res[31] != dec_a[31]);
            end
            ALUC_SUBU: begin
                res   = {1'b0, dec_a} - {1'b0, dec_b};
                carry = res[32];    // Borrow
            end
            ALUC_AND: res = {1'b0, dec_a & dec_b};
            ALUC_OR:  res = {1'b0, dec_a | dec_b};
            ALUC_XOR: res = {1'b0, dec_a ^ dec_b};
            ALUC_NOR: res = {1'b0, ~(dec_a | dec_b)};
            ALUC_SLT: begin
                cmp = $signed(dec_a) < $signed(dec_b);
                res = {32'd0, cmp};
            end
            ALUC_SLTU: begin
                cmp = dec_a < dec_b;
                res = {32'd0, cmp};
            end
            ALUC_SLL, ALUC_SLLV: res = {1'b0, dec_b << dec_a[4:0]};
            ALUC_SRL, ALUC_SRLV: res = {1'b0, dec_b >> dec_a[4:0]};
            ALUC_SRA, ALUC_SRAV: res = {1'b0, $signed(dec_b) >>> dec_a[4:0]};
            ALUC_LUI:            res = {1'b0, dec_a[15:0], 16'h0000};
            default:             res = 33'd0;
        endcase
    end

    // ==============================
    // Flags
    // ==============================
    always_comb begin
        nxt_flags = '0;
        if (dec_illegal) begin
            nxt_result               = 32'd0;
            nxt_flags[FLG_ILLEGAL]   = 1'b1;
            nxt_flags[FLG_ZERO]      = 1'b1;
        end else begin
            nxt_result               = res[31:0];
            nxt_flags[FLG_ZERO]      = (res[31:0] == 32'd0);
            nxt_flags[FLG_NEG]       = res[31];
            nxt_flags[FLG_CARRY]     = carry;
            nxt_flags[FLG_OVF]       = ovf;
            nxt_flags[FLG_CMP]       = cmp;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            alu_valid <= 1'b0;
        end else begin
            alu_valid <= dec_valid;
        end
    end

    always_ff @(posedge clk) begin
        alu_result <= nxt_result;
        alu_dest   <= dec_dest;
        alu_flags  <= nxt_flags;
    end

    // Decoder must hand over a real code unless it flagged the word
    a_known_aluc: assert property (@(posedge clk) disable iff (reset)
        (dec_valid && !dec_illegal) |-> dec_aluc inside {
            ALUC_ADD, ALUC_ADDU, ALUC_SUB, ALUC_SUBU, ALUC_AND, ALUC_OR,
            ALUC_XOR, ALUC_NOR, ALUC_SLT, ALUC_SLTU, ALUC_SLL, ALUC_SRL,
            ALUC_SRA, ALUC_SLLV, ALUC_SRLV, ALUC_SRAV, ALUC_LUI})
        else $error("alu: unknown function code %b from decoder", dec_aluc);

endmodule

// File: rtl/alu_decode.sv
`timescale 1ns/1ps

module alu_decode (
    input  logic             clk,
    input  logic             reset,
    input  logic             in_valid,
    input  exec_pkg::instr_t instr,
    input  logic [31:0]      rs_value,
    input  logic [31:0]      rt_value,
    output logic             dec_valid,
    output exec_pkg::aluc_t  dec_aluc,
    output logic [31:0]      dec_a,
    output logic [31:0]      dec_b,
    output logic [4:0]       dec_dest,
    output logic             dec_illegal
);
    import exec_pkg::*;

    aluc_t       nxt_aluc;
    logic [31:0] nxt_a;
    logic [31:0] nxt_b;
    logic [4:0]  nxt_dest;
    logic        nxt_illegal;
    logic [31:0] imm_sext;
    logic [31:0] imm_zext;

    assign imm_sext = {{16{instr.i.imm[15]}}, instr.i.imm};
    assign imm_zext = {16'h0000, instr.i.imm};

    // ==============================
    // Field decode
    // ==============================
    always_comb begin
        nxt_aluc    = ALUC_ADD;
        nxt_a       = rs_value;
        nxt_b       = imm_sext;       // Most I-types sign extend
        nxt_dest    = instr.i.rt;
        nxt_illegal = 1'b0;
        case (instr.r.opcode)
            OP_RTYPE: begin
                nxt_aluc = aluc_t'(instr.r.funct);
                nxt_b    = rt_value;
                nxt_dest = instr.r.rd;
                case (instr.r.funct)
                    ALUC_SLL, ALUC_SRL, ALUC_SRA: begin
                        nxt_a = {27'd0, instr.r.shamt};    // Fixed shift amount
                    end
                    ALUC_ADD, ALUC_ADDU, ALUC_SUB, ALUC_SUBU,
                    ALUC_AND, ALUC_OR, ALUC_XOR, ALUC_NOR,
                    ALUC_SLT, ALUC_SLTU,
                    ALUC_SLLV, ALUC_SRLV, ALUC_SRAV: begin
                        nxt_a = rs_value;
                    end
                    ALUC_JR: begin
                        nxt_aluc    = ALUC_ADD;
                        nxt_illegal = 1'b1;    // No ALU result for a jump
                    end
                    default: begin
                        nxt_aluc    = ALUC_ADD;
                        nxt_illegal = 1'b1;
                    end
                endcase
            end
            OP_ADDI:  nxt_aluc = ALUC_ADD;
            OP_ADDIU: nxt_aluc = ALUC_ADDU;
            OP_SLTI:  nxt_aluc = ALUC_SLT;
            OP_SLTIU: nxt_aluc = ALUC_SLTU;    // Sign extended, unsigned compare
            OP_ANDI: begin
                nxt_aluc = ALUC_AND;
                nxt_b    = imm_zext;
            end
            OP_ORI: begin
                nxt_aluc = ALUC_OR;
                nxt_b    = imm_zext;
            end
            OP_XORI: begin
                nxt_aluc = ALUC_XOR;
                nxt_b    = imm_zext;
            end
            OP_LUI: begin
                nxt_aluc = ALUC_LUI;
                nxt_a    = imm_zext;    // ALU takes a[15:0]
                nxt_b    = 32'd0;
            end
            default: nxt_illegal = 1'b1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        dec_aluc    <= nxt_aluc;
        dec_a       <= nxt_a;
        dec_b       <= nxt_b;
        dec_dest    <= nxt_dest;
        dec_illegal <= nxt_illegal;
    end

endmodule

// File: rtl/exec_pkg.sv
package exec_pkg;

    // ==============================
    // Major opcodes
    // ==============================
    typedef enum logic [5:0] {
        OP_RTYPE = 6'b000000,
        OP_ADDI  = 6'b001000,
        OP_ADDIU = 6'b001001,
        OP_SLTI  = 6'b001010,
        OP_SLTIU = 6'b001011,
        OP_ANDI  = 6'b001100,
        OP_ORI   = 6'b001101,
        OP_XORI  = 6'b001110,
        OP_LUI   = 6'b001111
    } op_t;

    // ==============================
    // ALU function codes
    // ==============================
    typedef enum logic [5:0] {
        ALUC_ADD  = 6'b100000,
        ALUC_ADDU = 6'b100001,
        ALUC_SUB  = 6'b100010,
        ALUC_SUBU = 6'b100011,
        ALUC_AND  = 6'b100100,
        ALUC_OR   = 6'b100101,
        ALUC_XOR  = 6'b100110,
        ALUC_NOR  = 6'b100111,
        ALUC_SLT  = 6'b101010,
        ALUC_SLTU = 6'b101011,
        ALUC_SLL  = 6'b000000,
        ALUC_SRL  = 6'b000010,
        ALUC_SRA  = 6'b000011,
        ALUC_SLLV = 6'b000100,
        ALUC_SRLV = 6'b000110,
        ALUC_SRAV = 6'b000111,
        ALUC_JR   = 6'b001000,    // Decoded only to be rejected
        ALUC_LUI  = 6'b001111     // Not a real funct, I-type only
    } aluc_t;

    // One instruction word, R and I views
    typedef union packed {
        struct packed {
            op_t        opcode;
            logic [4:0] rs;
            logic [4:0] rt;
            logic [4:0] rd;
            logic [4:0] shamt;
            logic [5:0] funct;
        } r;
        struct packed {
            op_t         opcode;
            logic [4:0]  rs;
            logic [4:0]  rt;
            logic [15:0] imm;
        } i;
    } instr_t;

    // ==============================
    // Result flags
    // ==============================
    typedef logic [5:0] flags_t;

    localparam int FLG_ZERO    = 0;
    localparam int FLG_CARRY   = 1;
    localparam int FLG_NEG     = 2;
    localparam int FLG_OVF     = 3;
    localparam int FLG_CMP     = 4;
    localparam int FLG_ILLEGAL = 5;

endpackage
